//--- fir_accel.f
+incdir+bench
design/fir_accel_pkg.sv
design/act_buffer.sv
design/weight_bank.sv
design/fir_pe_array.sv
design/out_buffer.sv
design/fir_ctrl.sv
design/fir_accel_top.sv
bench/fir_accel_tb.sv

//--- bench/fir_accel_tb_tasks.svh
`ifndef FIR_ACCEL_TB_TASKS_SVH
`define FIR_ACCEL_TB_TASKS_SVH

// **************************************************
// reference model
// **************************************************
function automatic result_t ref_fir(input int row, input int j);
    longint sum;
    longint lim;
    sum = 0;
    lim = longint'(1) <<< (RESULT_WIDTH - 1);
    for (int k = 0; k < NB_TAPS; k++) begin
        sum += longint'(tb_taps[k]) * longint'(tb_act[row][j + k]);
    end
    sum = sum >>> FRAC_SHIFT;                 // longint is signed
    if (sum > lim - 1) begin
        sum = lim - 1;
    end else if (sum < -lim) begin
        sum = -lim;
    end
    return result_t'(sum);
endfunction

task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_row(input string name, input integer exp, input integer act);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_index(input string name, input integer exp, input integer act);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
    end
endtask

// **************************************************
// load and run, called 2 ns after an edge
// **************************************************
task automatic load_tap(input int k, input weight_t value);
    logic accepted;
    accepted = 1'b0;
    w_tap    = TAP_W'(k);
    w_data   = value;
    w_valid  = 1'b1;
    while (!accepted) begin
        accepted = w_ready;                   // ready here is ready at the next edge
        @(posedge clk);
        #2;
    end
    w_valid    = 1'b0;
    tb_taps[k] = value;
endtask

task automatic load_act(input int row, input int addr, input act_t value);
    logic accepted;
    accepted = 1'b0;
    a_row    = ROW_W'(row);
    a_addr   = ADDR_W'(addr);
    a_data   = value;
    a_valid  = 1'b1;
    while (!accepted) begin
        accepted = a_ready;
        @(posedge clk);
        #2;
    end
    a_valid           = 1'b0;
    tb_act[row][addr] = value;
endtask

task automatic issue_cmd(input int n);
    logic accepted;
    accepted   = 1'b0;
    beat_count = 0;
    for (int j = 0; j <= n - NB_TAPS; j++) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_row.push_back(r);
            exp_idx.push_back(j);
            exp_data.push_back(ref_fir(r, j));
        end
    end
    cmd_len   = LEN_W'(n);
    cmd_valid = 1'b1;
    while (!accepted) begin
        accepted = cmd_ready;
        @(posedge clk);
        #2;
    end
    cmd_valid = 1'b0;
endtask

task automatic wait_done(input int n);
    int want;
    want = NUM_ROWS * (n - NB_TAPS + 1);
    while (busy) begin
        @(posedge clk);
        #2;
    end
    if (beat_count != want) begin
        other_errors++;
        $display("N=%0d gave %0d result beats instead of %0d", n, beat_count, want);
    end
    if (exp_data.size() != 0) begin
        other_errors++;
        $display("N=%0d left %0d expected results that never arrived", n, exp_data.size());
        exp_row.delete();
        exp_idx.delete();
        exp_data.delete();
    end
endtask

task automatic run_fir(input int n);
    issue_cmd(n);
    wait_done(n);
endtask

`endif

//--- bench/fir_accel_tb.sv
`timescale 1ns/1ps

module fir_accel_tb;
    import fir_accel_pkg::*;

    localparam int NUM_ROWS  = 4;
    localparam int NB_TAPS   = 11;
    localparam int ACT_DEPTH = 64;
    localparam int ROW_W     = $clog2(NUM_ROWS);
    localparam int TAP_W     = $clog2(NB_TAPS);
    localparam int ADDR_W    = $clog2(ACT_DEPTH);
    localparam int LEN_W     = $clog2(ACT_DEPTH + 1);
    // five commands: 20, 20, 20, NB_TAPS, ACT_DEPTH
    localparam int CMD_CYCLES    = (3 * 20 + NB_TAPS + ACT_DEPTH) * (NB_TAPS + 4 * NUM_ROWS);
    localparam int LOAD_CYCLES   = 4 * NB_TAPS + 2 * NUM_ROWS * ACT_DEPTH + NUM_ROWS * 20;
    localparam int TIMEOUT_LIMIT = CMD_CYCLES + LOAD_CYCLES + 200;

    logic clk;
    logic rst;
    logic w_valid, w_ready, a_valid, a_ready, cmd_valid, cmd_ready;
    logic out_valid, out_ready, busy;
    logic [TAP_W-1:0]  w_tap;
    logic [ROW_W-1:0]  a_row, out_row;
    logic [ADDR_W-1:0] a_addr, out_index;
    logic [LEN_W-1:0]  cmd_len;
    weight_t           w_data;
    act_t              a_data;
    result_t           out_data;

    weight_t tb_taps [NB_TAPS];
    act_t    tb_act [NUM_ROWS][ACT_DEPTH];
    int      exp_row[$];
    int      exp_idx[$];
    result_t exp_data[$];
    int      value_errors = 0;
    int      other_errors = 0;
    int      beat_count = 0;
    int      cycles = 0;
    logic    bp_mode;
    logic    bp_pattern [1024];
    logic    hold_pending = 1'b0;
    int      held_row, held_idx;
    result_t held_data;

    fir_accel_top #(
        .NUM_ROWS  (NUM_ROWS),
        .NB_TAPS   (NB_TAPS),
        .ACT_DEPTH (ACT_DEPTH)
    ) i_fir_accel_top (
        .clk(clk), .rst(rst),
        .w_valid(w_valid), .w_ready(w_ready), .w_tap(w_tap), .w_data(w_data),
        .a_valid(a_valid), .a_ready(a_ready), .a_row(a_row), .a_addr(a_addr),
        .a_data(a_data),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_len(cmd_len),
        .out_valid(out_valid), .out_ready(out_ready), .out_row(out_row),
        .out_index(out_index), .out_data(out_data), .busy(busy)
    );

    `include "fir_accel_tb_tasks.svh"

    function automatic int rand_pm(input int mag);
        return int'($urandom_range(2 * mag)) - mag;
    endfunction

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        #2;
        out_ready = bp_mode ? bp_pattern[cycles % 1024] : 1'b1;
    end

    // **************************************************
    // scoreboard, sampled mid-cycle
    // **************************************************
    always @(negedge clk) begin
        if (!rst) begin
            if (hold_pending) begin
                check_flag("out_valid held", 1'b1, out_valid);
                check_row("out_row held", held_row, out_row);
                check_index("out_index held", held_idx, out_index);
                check_result("out_data held", held_data, out_data);
            end
            hold_pending = out_valid && !out_ready;
            held_row     = out_row;
            held_idx     = out_index;
            held_data    = out_data;
            if (out_valid && out_ready) begin
                beat_count++;
                if (exp_data.size() == 0) begin
                    other_errors++;
                    $display("extra beat for row %0d index %0d", out_row, out_index);
                end else begin
                    check_row("out_row", exp_row.pop_front(), out_row);
                    check_index("out_index", exp_idx.pop_front(), out_index);
                    check_result("out_data", exp_data.pop_front(), out_data);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_LIMIT) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, the run did not complete", cycles);
        $display("errors: %0d value, %0d protocol", value_errors, other_errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(18699));
        for (int i = 0; i < 1024; i++) begin
            bp_pattern[i] = 1'($urandom % 2);
        end
        rst = 1'b1;
        {w_valid, a_valid, cmd_valid} = '0;
        w_tap = '0;
        w_data = '0;
        a_row = '0;
        a_addr = '0;
        a_data = '0;
        cmd_len = '0;
        bp_mode = 1'b0;
        out_ready = 1'b1;

        repeat (8) begin
            @(posedge clk);
            #2;
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("busy", 1'b0, busy);
        end
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_flag("w_ready", 1'b1, w_ready);
        check_flag("a_ready", 1'b1, a_ready);
        check_flag("cmd_ready", 1'b1, cmd_ready);
        check_flag("busy", 1'b0, busy);

        // basic random convolution
        for (int k = 0; k < NB_TAPS; k++) load_tap(k, weight_t'(rand_pm(2000)));
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int a = 0; a < ACT_DEPTH; a++) load_act(r, a, act_t'(rand_pm(2000)));
        end
        run_fir(20);

        // near full scale, both signs
        for (int k = 0; k < NB_TAPS; k++) load_tap(k, (k % 2 == 0) ? 16'sd32767 : 16'sd32000);
        for (int a = 0; a < 20; a++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                case (r % 4)
                    0:       load_act(r, a, 16'sd32767);
                    1:       load_act(r, a, -16'sd32768);
                    2:       load_act(r, a, (a % 2) ? 16'sd30000 : -16'sd30000);
                    default: load_act(r, a, act_t'(rand_pm(32767)));
                endcase
            end
        end
        run_fir(20);

        // back-pressure on fresh random data
        for (int k = 0; k < NB_TAPS; k++) load_tap(k, weight_t'(rand_pm(2000)));
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int a = 0; a < ACT_DEPTH; a++) load_act(r, a, act_t'(rand_pm(2000)));
        end
        bp_mode = 1'b1;
        run_fir(20);
        bp_mode = 1'b0;

        // new taps over old activations, command blocked while busy
        for (int k = 0; k < NB_TAPS; k++) load_tap(k, weight_t'(rand_pm(2000)));
        issue_cmd(ACT_DEPTH);
        cmd_len   = LEN_W'(20);
        cmd_valid = 1'b1;
        repeat (3) begin
            check_flag("busy", 1'b1, busy);
            check_flag("w_ready", 1'b0, w_ready);
            check_flag("a_ready", 1'b0, a_ready);
            check_flag("cmd_ready", 1'b0, cmd_ready);
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b0;
        wait_done(ACT_DEPTH);
        run_fir(NB_TAPS);

        $display("errors: %0d value, %0d protocol", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- design/fir_accel_top.sv
`timescale 1ns/1ps

module fir_accel_top #(
    parameter int  NUM_ROWS  = 4,
    parameter int  NB_TAPS   = 11,
    parameter int  ACT_DEPTH = 64,
    localparam int ROW_W     = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
    localparam int TAP_W     = (NB_TAPS > 1) ? $clog2(NB_TAPS) : 1,
    localparam int ADDR_W    = $clog2(ACT_DEPTH),
    localparam int LEN_W     = $clog2(ACT_DEPTH + 1)
) (
    input  logic                   clk,
    input  logic                   rst,
    // tap load
    input  logic                   w_valid,
    output logic                   w_ready,
    input  logic [TAP_W-1:0]       w_tap,
    input  fir_accel_pkg::weight_t w_data,
    // activation load
    input  logic                   a_valid,
    output logic                   a_ready,
    input  logic [ROW_W-1:0]       a_row,
    input  logic [ADDR_W-1:0]      a_addr,
    input  fir_accel_pkg::act_t    a_data,
    // command
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [LEN_W-1:0]       cmd_len,
    // results
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [ROW_W-1:0]       out_row,
    output logic [ADDR_W-1:0]      out_index,
    output fir_accel_pkg::result_t out_data,
    output logic                   busy
);
    import fir_accel_pkg::*;

    // **************************************************
    // controller to datapath
    // **************************************************
    logic                act_we;
    logic [ROW_W-1:0]    act_wrow;
    logic [ADDR_W-1:0]   act_waddr;
    act_t                act_wdata;
    logic                act_re;
    logic [ADDR_W-1:0]   act_raddr;
    logic                wb_we;
    logic [TAP_W-1:0]    wb_wtap;
    weight_t             wb_wdata;
    logic                wb_re;
    logic [TAP_W-1:0]    wb_rtap;
    logic                mac_en;
    logic                mac_first;
    logic                ob_we;
    logic [ADDR_W-1:0]   ob_waddr;
    logic                ob_re;
    logic [ROW_W-1:0]    ob_rrow;
    logic [ADDR_W-1:0]   ob_raddr;

    // datapath to datapath
    act_t [NUM_ROWS-1:0]    act_rdata;
    weight_t                tap_rdata;
    result_t [NUM_ROWS-1:0] pe_result;
    result_t                ob_rdata;

    fir_ctrl #(
        .NUM_ROWS  (NUM_ROWS),
        .NB_TAPS   (NB_TAPS),
        .ACT_DEPTH (ACT_DEPTH)
    ) u_fir_ctrl (
        .clk       (clk),       .rst       (rst),
        .w_valid   (w_valid),   .w_ready   (w_ready),   .w_tap    (w_tap),
        .w_data    (w_data),
        .a_valid   (a_valid),   .a_ready   (a_ready),   .a_row    (a_row),
        .a_addr    (a_addr),    .a_data    (a_data),
        .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd_len  (cmd_len),
        .out_valid (out_valid), .out_ready (out_ready), .out_row  (out_row),
        .out_index (out_index), .out_data  (out_data),  .busy     (busy),
        .ob_rdata  (ob_rdata),
        .act_we    (act_we),    .act_wrow  (act_wrow),  .act_waddr (act_waddr),
        .act_wdata (act_wdata), .act_re    (act_re),    .act_raddr (act_raddr),
        .wb_we     (wb_we),     .wb_wtap   (wb_wtap),   .wb_wdata  (wb_wdata),
        .wb_re     (wb_re),     .wb_rtap   (wb_rtap),
        .mac_en    (mac_en),    .mac_first (mac_first),
        .ob_we     (ob_we),     .ob_waddr  (ob_waddr),
        .ob_re     (ob_re),     .ob_rrow   (ob_rrow),   .ob_raddr  (ob_raddr)
    );

    act_buffer #(.NUM_ROWS(NUM_ROWS), .ACT_DEPTH(ACT_DEPTH)) u_act_buffer (
        .clk   (clk),      .we    (act_we),    .wrow  (act_wrow),
        .waddr (act_waddr), .wdata (act_wdata), .re    (act_re),
        .raddr (act_raddr), .rdata (act_rdata)
    );

    weight_bank #(.NB_TAPS(NB_TAPS)) u_weight_bank (
        .clk   (clk),   .rst   (rst),      .we    (wb_we),   .wtap (wb_wtap),
        .wdata (wb_wdata), .re (wb_re),    .rtap  (wb_rtap), .rdata (tap_rdata)
    );

    fir_pe_array #(.NUM_ROWS(NUM_ROWS)) u_fir_pe_array (
        .clk       (clk),       .rst    (rst),       .mac_en (mac_en),
        .mac_first (mac_first), .act_in (act_rdata), .tap_in (tap_rdata),
        .result    (pe_result)
    );

    out_buffer #(.NUM_ROWS(NUM_ROWS), .ACT_DEPTH(ACT_DEPTH)) u_out_buffer (
        .clk   (clk),      .we    (ob_we),    .waddr (ob_waddr),
        .wdata (pe_result), .re   (ob_re),    .rrow  (ob_rrow),
        .raddr (ob_raddr), .rdata (ob_rdata)
    );

endmodule

//--- design/fir_ctrl.sv
`timescale 1ns/1ps

module fir_ctrl #(
    parameter int  NUM_ROWS  = 4,
    parameter int  NB_TAPS   = 11,
    parameter int  ACT_DEPTH = 64,
    localparam int ROW_W     = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
    localparam int TAP_W     = (NB_TAPS > 1) ? $clog2(NB_TAPS) : 1,
    localparam int ADDR_W    = $clog2(ACT_DEPTH),
    localparam int LEN_W     = $clog2(ACT_DEPTH + 1)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  logic [TAP_W-1:0]       w_tap,
    input  fir_accel_pkg::weight_t w_data,
    input  logic                   a_valid,
    output logic                   a_ready,
    input  logic [ROW_W-1:0]       a_row,
    input  logic [ADDR_W-1:0]      a_addr,
    input  fir_accel_pkg::act_t    a_data,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [LEN_W-1:0]       cmd_len,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [ROW_W-1:0]       out_row,
    output logic [ADDR_W-1:0]      out_index,
    output fir_accel_pkg::result_t out_data,
    output logic                   busy,
    input  fir_accel_pkg::result_t ob_rdata,
    output logic                   act_we,
    output logic [ROW_W-1:0]       act_wrow,
    output logic [ADDR_W-1:0]      act_waddr,
    output fir_accel_pkg::act_t    act_wdata,
    output logic                   act_re,
    output logic [ADDR_W-1:0]      act_raddr,
    output logic                   wb_we,
    output logic [TAP_W-1:0]       wb_wtap,
    output fir_accel_pkg::weight_t wb_wdata,
    output logic                   wb_re,
    output logic [TAP_W-1:0]       wb_rtap,
    output logic                   mac_en,
    output logic                   mac_first,
    output logic                   ob_we,
    output logic [ADDR_W-1:0]      ob_waddr,
    output logic                   ob_re,
    output logic [ROW_W-1:0]       ob_rrow,
    output logic [ADDR_W-1:0]      ob_raddr
);
    import fir_accel_pkg::*;

    ctrl_state_t       state;
    logic [ADDR_W-1:0] last_j;               // N - NB_TAPS
    logic [ADDR_W-1:0] idx;
    logic [TAP_W-1:0]  tap;
    logic              run_v1, run_first1, run_last1, run_last2;
    logic [ADDR_W-1:0] idx1, idx2;
    logic [ADDR_W-1:0] s_idx;
    logic [ROW_W-1:0]  s_row;
    logic              rd_done;              // all reads issued
    logic              idle, cmd_ok, tap_last, idx_last, row_last, out_free;

    assign idle     = (state == IDLE);
    assign cmd_ok   = (cmd_len >= LEN_W'(NB_TAPS)) && (cmd_len <= LEN_W'(ACT_DEPTH));
    assign tap_last = (tap == TAP_W'(NB_TAPS - 1));
    assign idx_last = (idx == last_j);
    assign row_last = (s_row == ROW_W'(NUM_ROWS - 1));
    assign out_free = !out_valid || out_ready;

    assign w_ready   = idle;
    assign a_ready   = idle;
    assign cmd_ready = idle;
    assign busy      = !idle;

    // loads go straight to the banks
    assign act_we    = a_valid && idle;
    assign act_wrow  = a_row;
    assign act_waddr = a_addr;
    assign act_wdata = a_data;
    assign wb_we     = w_valid && idle;
    assign wb_wtap   = w_tap;
    assign wb_wdata  = w_data;

    assign act_re    = (state == RUN);
    assign act_raddr = idx + ADDR_W'(tap);
    assign wb_re     = (state == RUN);
    assign wb_rtap   = tap;

    assign mac_en    = run_v1;
    assign mac_first = run_first1;
    assign ob_we     = run_last2;             // result sits in acc one cycle after last MAC
    assign ob_waddr  = idx2;

    assign ob_re     = (state == STREAM) && !rd_done && out_free;
    assign ob_rrow   = s_row;
    assign ob_raddr  = s_idx;
    assign out_data  = ob_rdata;              // read register holds while stalled

    // **************************************************
    // main FSM
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            last_j    <= '0;
            idx       <= '0;
            tap       <= '0;
            s_idx     <= '0;
            s_row     <= '0;
            rd_done   <= 1'b0;
            out_valid <= 1'b0;
            out_row   <= '0;
            out_index <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid && cmd_ok) begin
                        last_j <= ADDR_W'(cmd_len - LEN_W'(NB_TAPS));
                        idx    <= '0;
                        tap    <= '0;
                        state  <= RUN;
                    end
                end
                RUN: begin
                    if (tap_last) begin
                        tap <= '0;
                        if (idx_last) begin
                            state <= FLUSH;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
                FLUSH: begin
                    if (run_last2 && (idx2 == last_j)) begin
                        s_idx   <= '0;
                        s_row   <= '0;
                        rd_done <= 1'b0;
                        state   <= STREAM;
                    end
                end
                STREAM: begin
                    if (ob_re) begin
                        out_valid <= 1'b1;
                        out_row   <= s_row;
                        out_index <= s_idx;
                        if (row_last) begin
                            s_row <= '0;
                            s_idx <= s_idx + 1'b1;
                        end else begin
                            s_row <= s_row + 1'b1;
                        end
                        if (row_last && (s_idx == last_j)) begin
                            rd_done <= 1'b1;
                        end
                    end else if (out_valid && out_ready) begin
                        out_valid <= 1'b0;
                        if (rd_done) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // flags follow the read by one cycle, the write by two
    always_ff @(posedge clk) begin
        if (rst) begin
            run_v1     <= 1'b0;
            run_first1 <= 1'b0;
            run_last1  <= 1'b0;
            run_last2  <= 1'b0;
        end else begin
            run_v1     <= (state == RUN);
            run_first1 <= (state == RUN) && (tap == '0);
            run_last1  <= (state == RUN) && tap_last;
            run_last2  <= run_last1;
        end
    end

    always_ff @(posedge clk) begin
        idx1 <= idx;
        idx2 <= idx1;
    end

endmodule

//--- design/out_buffer.sv
`timescale 1ns/1ps

module out_buffer #(
    parameter int  NUM_ROWS  = 4,
    parameter int  ACT_DEPTH = 64,
    localparam int ROW_W     = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
    localparam int ADDR_W    = $clog2(ACT_DEPTH)
) (
    input  logic                                  clk,
    input  logic                                  we,
    input  logic [ADDR_W-1:0]                     waddr,
    input  fir_accel_pkg::result_t [NUM_ROWS-1:0] wdata,
    input  logic                                  re,
    input  logic [ROW_W-1:0]                      rrow,
    input  logic [ADDR_W-1:0]                     raddr,
    output fir_accel_pkg::result_t                rdata
);
    import fir_accel_pkg::*;

    result_t mem [NUM_ROWS][ACT_DEPTH];

    // all rows land at the same index
    always_ff @(posedge clk) begin
        if (we) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                mem[r][waddr] <= wdata[r];
            end
        end
    end

    // holds last entry when re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[rrow][raddr];
        end
    end

endmodule

//--- design/fir_pe_array.sv
`timescale 1ns/1ps

module fir_pe_array #(
    parameter int NUM_ROWS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  mac_en,
    input  logic                                  mac_first,
    input  fir_accel_pkg::act_t [NUM_ROWS-1:0]    act_in,
    input  fir_accel_pkg::weight_t                tap_in,
    output fir_accel_pkg::result_t [NUM_ROWS-1:0] result
);
    import fir_accel_pkg::*;

    genvar r;
    generate
        for (r = 0; r < NUM_ROWS; r++) begin : g_pe
            act_t                                     a;
            logic signed [ACT_WIDTH+WEIGHT_WIDTH-1:0] prod;
            acc_t                                     acc;
            acc_t                                     scaled;

            assign a    = act_in[r];       // keep the signed element type
            assign prod = a * tap_in;

            always_ff @(posedge clk) begin
                if (rst) begin
                    acc <= '0;
                end else if (mac_en) begin
                    if (mac_first) begin
                        acc <= acc_t'(prod);   // new index
                    end else begin
                        acc <= acc + acc_t'(prod);
                    end
                end
            end

            // rescale, then clamp to result range
            assign scaled    = acc >>> FRAC_SHIFT;
            assign result[r] = (scaled > RESULT_MAX) ? result_t'(RESULT_MAX) :
                               (scaled < RESULT_MIN) ? result_t'(RESULT_MIN) :
                                                       result_t'(scaled);
        end
    endgenerate

endmodule

//--- design/weight_bank.sv
`timescale 1ns/1ps

module weight_bank #(
    parameter int  NB_TAPS = 11,
    localparam int TAP_W   = (NB_TAPS > 1) ? $clog2(NB_TAPS) : 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  logic [TAP_W-1:0]       wtap,
    input  fir_accel_pkg::weight_t wdata,
    input  logic                   re,
    input  logic [TAP_W-1:0]       rtap,
    output fir_accel_pkg::weight_t rdata
);
    import fir_accel_pkg::*;

    weight_t taps [NB_TAPS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NB_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (we) begin
            taps[wtap] <= wdata;
        end
    end

    // registered to line up with act_buffer read
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= taps[rtap];
        end
    end

endmodule

//--- design/act_buffer.sv
`timescale 1ns/1ps

module act_buffer #(
    parameter int  NUM_ROWS  = 4,
    parameter int  ACT_DEPTH = 64,
    localparam int ROW_W     = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
    localparam int ADDR_W    = $clog2(ACT_DEPTH)
) (
    input  logic                               clk,
    input  logic                               we,
    input  logic [ROW_W-1:0]                   wrow,
    input  logic [ADDR_W-1:0]                  waddr,
    input  fir_accel_pkg::act_t                wdata,
    input  logic                               re,
    input  logic [ADDR_W-1:0]                  raddr,
    output fir_accel_pkg::act_t [NUM_ROWS-1:0] rdata
);
    import fir_accel_pkg::*;

    // one bank per PE row
    act_t mem [NUM_ROWS][ACT_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrow][waddr] <= wdata;
        end
    end

    // same address from every bank
    always_ff @(posedge clk) begin
        if (re) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                rdata[r] <= mem[r][raddr];
            end
        end
    end

endmodule

//--- design/fir_accel_pkg.sv
package fir_accel_pkg;

    // **************************************************
    // datapath widths
    // **************************************************
    localparam int ACT_WIDTH    = 16;
    localparam int WEIGHT_WIDTH = 16;
    localparam int ACC_WIDTH    = 40;  // headroom for up to 256 taps
    localparam int RESULT_WIDTH = 24;

    typedef logic signed [ACT_WIDTH-1:0]    act_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [RESULT_WIDTH-1:0] result_t;

    // **************************************************
    // rescale and clamp
    // **************************************************
    localparam int FRAC_SHIFT = 8;

    // limits of result_t, held at accumulator width
    localparam acc_t RESULT_MAX = (acc_t'(1) <<< (RESULT_WIDTH - 1)) - acc_t'(1);
    localparam acc_t RESULT_MIN = -(acc_t'(1) <<< (RESULT_WIDTH - 1));

    // controller states
    typedef enum logic [1:0] {
        IDLE,    // loads and commands accepted
        RUN,     // reads issued, MACs in flight
        FLUSH,   // drain last write
        STREAM   // results to host
    } ctrl_state_t;

endpackage
